// File: Makefile
VERILATOR  ?= verilator
TOP        ?= dcache_tb
RTL_TOP    ?= dcache_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation finished: PASS
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS ?= --timing -Wall -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
hw/dcache_geom_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_ways.sv
hw/dcache_flush_walker.sv
hw/dcache_mem_port.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tests/tb_main_memory.sv
tests/dcache_tb.sv

// File: hw/dcache_bus_pkg.sv
`default_nettype none

package dcache_bus_pkg;

    // Load value seen by the datapath while no hit is signalled
    localparam dcache_geom_pkg::word_t MISS_LOAD_VALUE = 32'hBAD1BAD1;

    // Datapath side
    typedef struct packed {
        logic                        ren;
        logic                        wen;
        dcache_geom_pkg::dcache_addr_t addr;
        dcache_geom_pkg::word_t      store;
    } dp_req_t;

    typedef struct packed {
        logic                   hit;
        dcache_geom_pkg::word_t load;
    } dp_rsp_t;

    // Memory side, one word per transfer
    typedef struct packed {
        logic                   ren;
        logic                   wen;
        dcache_geom_pkg::word_t addr;
        dcache_geom_pkg::word_t store;
    } mem_req_t;

    // dwait high means the current word is not done yet
    typedef struct packed {
        logic                   dwait;
        dcache_geom_pkg::word_t load;
    } mem_rsp_t;

    // Frame update requested by the FSM
    typedef enum logic [2:0] {
        FOP_NONE,
        FOP_WRITE,
        FOP_FILL0,
        FOP_FILL1,
        FOP_CLEAN
    } frame_op_t;

    // Which block a memory transfer belongs to
    typedef enum logic [1:0] {
        XFER_VICTIM,
        XFER_FILL,
        XFER_FLUSH
    } xfer_kind_t;

endpackage

`default_nettype wire

// File: hw/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  logic                        CLK,
    input  logic                        nRST,
    input  dcache_bus_pkg::dp_req_t     dp_req,
    input  logic                        halt,
    input  logic                        hit,
    input  dcache_geom_pkg::way_sel_t   hit_way,
    input  logic                        victim_dirty,
    input  logic                        flush_dirty,
    input  logic                        flush_done,
    input  logic                        mem_wait,
    input  dcache_geom_pkg::word_t      load_word,
    output dcache_bus_pkg::dp_rsp_t     dp_rsp,
    output logic                        flushed,
    output logic                        mem_ren,
    output logic                        mem_wen,
    output dcache_bus_pkg::xfer_kind_t  kind,
    output logic                        word_sel,
    output dcache_bus_pkg::frame_op_t   frame_op,
    output dcache_geom_pkg::way_sel_t   op_way,
    output dcache_geom_pkg::way_sel_t   victim_way,
    output logic                        walk_start,
    output logic                        walk_step
);

    typedef enum logic [3:0] {
        ST_LOOKUP,
        ST_WB0,
        ST_WB1,
        ST_ALLOC0,
        ST_ALLOC1,
        ST_FLUSH_SCAN,
        ST_FLUSH_W0,
        ST_FLUSH_W1,
        ST_FLUSHED
    } state_t;

    state_t state_q, state_d;

    // Global replacement bit, picks the victim way
    dcache_geom_pkg::way_sel_t repl_q, repl_d;

    logic rsp_hit;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= ST_LOOKUP;
            repl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            repl_q  <= repl_d;
        end
    end

    // Hit only counts in lookup with a live request
    // Halt wins over a pending request
    assign rsp_hit = (state_q == ST_LOOKUP) && !halt &&
                     (dp_req.ren || dp_req.wen) && hit;

    assign dp_rsp.hit  = rsp_hit;
    assign dp_rsp.load = rsp_hit ? load_word : dcache_bus_pkg::MISS_LOAD_VALUE;

    assign flushed    = (state_q == ST_FLUSHED);
    assign victim_way = repl_q;

    always_comb begin
        state_d    = state_q;
        repl_d     = repl_q;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        kind       = dcache_bus_pkg::XFER_FILL;
        word_sel   = 1'b0;
        frame_op   = dcache_bus_pkg::FOP_NONE;
        op_way     = repl_q;
        walk_start = 1'b0;
        walk_step  = 1'b0;

        case (state_q)
            ST_LOOKUP: begin
                if (halt) begin
                    walk_start = 1'b1;
                    state_d    = ST_FLUSH_SCAN;
                end else if (dp_req.ren || dp_req.wen) begin
                    if (hit) begin
                        // Write hit lands at the next edge
                        if (dp_req.wen) begin
                            frame_op = dcache_bus_pkg::FOP_WRITE;
                            op_way   = hit_way;
                        end
                    end else begin
                        state_d = victim_dirty ? ST_WB0 : ST_ALLOC0;
                    end
                end
            end

            // Dirty victim goes out first
            ST_WB0: begin
                mem_wen = 1'b1;
                kind    = dcache_bus_pkg::XFER_VICTIM;
                if (!mem_wait) begin
                    state_d = ST_WB1;
                end
            end

            ST_WB1: begin
                mem_wen  = 1'b1;
                kind     = dcache_bus_pkg::XFER_VICTIM;
                word_sel = 1'b1;
                if (!mem_wait) begin
                    state_d = ST_ALLOC0;
                end
            end

            // Fill into the replacement way
            ST_ALLOC0: begin
                mem_ren = 1'b1;
                if (!mem_wait) begin
                    frame_op = dcache_bus_pkg::FOP_FILL0;
                    state_d  = ST_ALLOC1;
                end
            end

            ST_ALLOC1: begin
                mem_ren  = 1'b1;
                word_sel = 1'b1;
                if (!mem_wait) begin
                    frame_op = dcache_bus_pkg::FOP_FILL1;
                    repl_d   = ~repl_q;
                    state_d  = ST_LOOKUP;
                end
            end

            // One cycle per clean frame
            ST_FLUSH_SCAN: begin
                if (flush_done) begin
                    state_d = ST_FLUSHED;
                end else if (flush_dirty) begin
                    state_d = ST_FLUSH_W0;
                end else begin
                    walk_step = 1'b1;
                end
            end

            ST_FLUSH_W0: begin
                mem_wen = 1'b1;
                kind    = dcache_bus_pkg::XFER_FLUSH;
                if (!mem_wait) begin
                    state_d = ST_FLUSH_W1;
                end
            end

            ST_FLUSH_W1: begin
                mem_wen  = 1'b1;
                kind     = dcache_bus_pkg::XFER_FLUSH;
                word_sel = 1'b1;
                if (!mem_wait) begin
                    // Mark clean and move on together
                    frame_op  = dcache_bus_pkg::FOP_CLEAN;
                    walk_step = 1'b1;
                    state_d   = ST_FLUSH_SCAN;
                end
            end

            // Stays here until reset
            ST_FLUSHED: ;

            default: state_d = ST_LOOKUP;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/dcache_flush_walker.sv
`default_nettype none

module dcache_flush_walker (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      start,
    input  logic                      step,
    output dcache_geom_pkg::way_sel_t way,
    output dcache_geom_pkg::set_idx_t set,
    output logic                      done
);

    localparam int IDX_W = dcache_geom_pkg::IDX_W;

    // Way in the top bit, set below it
    logic [IDX_W:0] pos_q;
    logic           done_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pos_q  <= '0;
            done_q <= 1'b0;
        end else if (start) begin
            // Restart at way 0 set 0
            pos_q  <= '0;
            done_q <= 1'b0;
        end else if (step && !done_q) begin
            pos_q <= pos_q + 1'b1;
            // Last frame of way 1 just stepped past
            if (pos_q == '1) begin
                done_q <= 1'b1;
            end
        end
    end

    assign way  = pos_q[IDX_W];
    assign set  = pos_q[IDX_W-1:0];
    assign done = done_q;

endmodule

`default_nettype wire

// File: hw/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

    // Word and cache shape
    localparam int WORD_W    = 32;
    localparam int WAY_COUNT = 2;
    localparam int SET_COUNT = 8;

    // Address field widths
    localparam int IDX_W = 3;
    localparam int BLK_W = 1;
    localparam int BYT_W = 2;
    localparam int TAG_W = WORD_W - IDX_W - BLK_W - BYT_W;

    typedef logic [WORD_W-1:0] word_t;

    // Byte address as the cache sees it
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [BLK_W-1:0] blkoff;
        logic [BYT_W-1:0] bytoff;
    } dcache_addr_t;

    // One block frame, two words of payload
    typedef struct packed {
        logic                      valid;
        logic                      dirty;
        logic [TAG_W-1:0]          tag;
        word_t [(1<<BLK_W)-1:0]    data;
    } dcache_frame_t;

    typedef logic             way_sel_t;
    typedef logic [IDX_W-1:0] set_idx_t;

endpackage

`default_nettype wire

// File: hw/dcache_mem_port.sv
`default_nettype none

module dcache_mem_port (
    input  dcache_bus_pkg::xfer_kind_t     kind,
    input  logic                           word_sel,
    input  dcache_geom_pkg::dcache_addr_t  req_addr,
    input  dcache_geom_pkg::dcache_frame_t victim_frame,
    input  dcache_geom_pkg::dcache_frame_t flush_frame,
    input  dcache_geom_pkg::set_idx_t      flush_set,
    output dcache_geom_pkg::word_t         mem_addr,
    output dcache_geom_pkg::word_t         mem_store
);

    dcache_geom_pkg::dcache_addr_t fill_addr;
    dcache_geom_pkg::dcache_addr_t victim_addr;
    dcache_geom_pkg::dcache_addr_t flush_addr;

    always_comb begin
        // Fill reads the requested block word by word
        fill_addr        = req_addr;
        fill_addr.blkoff = word_sel;

        // Victim lives in the request set under its own tag
        victim_addr.tag    = victim_frame.tag;
        victim_addr.idx    = req_addr.idx;
        victim_addr.blkoff = word_sel;
        victim_addr.bytoff = '0;

        // Flush block comes from the walker position
        flush_addr.tag    = flush_frame.tag;
        flush_addr.idx    = flush_set;
        flush_addr.blkoff = word_sel;
        flush_addr.bytoff = '0;
    end

    always_comb begin
        case (kind)
            dcache_bus_pkg::XFER_VICTIM: begin
                mem_addr  = victim_addr;
                mem_store = victim_frame.data[word_sel];
            end
            dcache_bus_pkg::XFER_FLUSH: begin
                mem_addr  = flush_addr;
                mem_store = flush_frame.data[word_sel];
            end
            default: begin
                // Reads carry no store data
                mem_addr  = fill_addr;
                mem_store = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`default_nettype none

module dcache_top (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_bus_pkg::dp_req_t  dp_req,
    output dcache_bus_pkg::dp_rsp_t  dp_rsp,
    input  logic                     halt,
    output logic                     flushed,
    output dcache_bus_pkg::mem_req_t mem_req,
    input  dcache_bus_pkg::mem_rsp_t mem_rsp
);

    // Lookup results
    logic                           hit;
    dcache_geom_pkg::way_sel_t      hit_way;
    dcache_geom_pkg::word_t         load_word;
    dcache_geom_pkg::dcache_frame_t victim_frame;
    dcache_geom_pkg::dcache_frame_t flush_frame;

    // Controller commands
    dcache_bus_pkg::xfer_kind_t     kind;
    logic                           word_sel;
    dcache_bus_pkg::frame_op_t      frame_op;
    dcache_geom_pkg::way_sel_t      op_way;
    dcache_geom_pkg::way_sel_t      victim_way;
    logic                           walk_start;
    logic                           walk_step;

    // Flush walker position
    dcache_geom_pkg::way_sel_t      walk_way;
    dcache_geom_pkg::set_idx_t      walk_set;
    logic                           walk_done;

    dcache_ctrl ctrl0 (
        .CLK(CLK), .nRST(nRST), .dp_req(dp_req), .halt(halt),
        .hit(hit), .hit_way(hit_way), .victim_dirty(victim_frame.dirty),
        .flush_dirty(flush_frame.dirty), .flush_done(walk_done),
        .mem_wait(mem_rsp.dwait), .load_word(load_word), .dp_rsp(dp_rsp),
        .flushed(flushed), .mem_ren(mem_req.ren), .mem_wen(mem_req.wen),
        .kind(kind), .word_sel(word_sel), .frame_op(frame_op), .op_way(op_way),
        .victim_way(victim_way), .walk_start(walk_start), .walk_step(walk_step)
    );

    // Updates always target the request set, flush clean uses the walker
    dcache_ways ways0 (
        .CLK(CLK), .nRST(nRST), .lookup_addr(dp_req.addr), .frame_op(frame_op),
        .op_way(op_way), .op_set(dp_req.addr.idx), .store_word(dp_req.store),
        .fill_word(mem_rsp.load), .hit(hit), .hit_way(hit_way),
        .load_word(load_word), .victim_frame(victim_frame),
        .flush_frame(flush_frame), .flush_set(walk_set), .flush_way(walk_way),
        .victim_way(victim_way)
    );

    dcache_flush_walker walker0 (
        .CLK(CLK), .nRST(nRST), .start(walk_start), .step(walk_step),
        .way(walk_way), .set(walk_set), .done(walk_done)
    );

    dcache_mem_port port0 (
        .kind(kind), .word_sel(word_sel), .req_addr(dp_req.addr),
        .victim_frame(victim_frame), .flush_frame(flush_frame),
        .flush_set(walk_set), .mem_addr(mem_req.addr), .mem_store(mem_req.store)
    );

endmodule

`default_nettype wire

// File: hw/dcache_ways.sv
`default_nettype none

module dcache_ways (
    input  logic                          CLK,
    input  logic                          nRST,
    input  dcache_geom_pkg::dcache_addr_t lookup_addr,
    input  dcache_bus_pkg::frame_op_t     frame_op,
    input  dcache_geom_pkg::way_sel_t     op_way,
    input  dcache_geom_pkg::set_idx_t     op_set,
    input  dcache_geom_pkg::word_t        store_word,
    input  dcache_geom_pkg::word_t        fill_word,
    output logic                          hit,
    output dcache_geom_pkg::way_sel_t     hit_way,
    output dcache_geom_pkg::word_t        load_word,
    output dcache_geom_pkg::dcache_frame_t victim_frame,
    output dcache_geom_pkg::dcache_frame_t flush_frame,
    input  dcache_geom_pkg::set_idx_t     flush_set,
    input  dcache_geom_pkg::way_sel_t     flush_way,
    input  dcache_geom_pkg::way_sel_t     victim_way
);

    localparam int WAYS = dcache_geom_pkg::WAY_COUNT;
    localparam int SETS = dcache_geom_pkg::SET_COUNT;

    // State bits per frame
    logic [WAYS-1:0][SETS-1:0] valid_q;
    logic [WAYS-1:0][SETS-1:0] dirty_q;

    // Tag and payload arrays
    logic [dcache_geom_pkg::TAG_W-1:0] tag_q [WAYS][SETS];
    dcache_geom_pkg::word_t [(1<<dcache_geom_pkg::BLK_W)-1:0] data_q [WAYS][SETS];

    logic [WAYS-1:0] match;

    // Tag compare in both ways of the indexed set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_q[w][lookup_addr.idx] &&
                       (tag_q[w][lookup_addr.idx] == lookup_addr.tag);
        end
    end

    assign hit       = |match;
    // Only one way can match a given tag
    assign hit_way   = match[1];
    assign load_word = data_q[hit_way][lookup_addr.idx][lookup_addr.blkoff];

    // Victim frame at the request set
    always_comb begin
        victim_frame.valid = valid_q[victim_way][lookup_addr.idx];
        victim_frame.dirty = dirty_q[victim_way][lookup_addr.idx];
        victim_frame.tag   = tag_q[victim_way][lookup_addr.idx];
        victim_frame.data  = data_q[victim_way][lookup_addr.idx];
    end

    // Frame under the flush walker
    always_comb begin
        flush_frame.valid = valid_q[flush_way][flush_set];
        flush_frame.dirty = dirty_q[flush_way][flush_set];
        flush_frame.tag   = tag_q[flush_way][flush_set];
        flush_frame.data  = data_q[flush_way][flush_set];
    end

    // Valid and dirty updates
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (frame_op)
                dcache_bus_pkg::FOP_WRITE: dirty_q[op_way][op_set] <= 1'b1;
                dcache_bus_pkg::FOP_FILL1: begin
                    // Block complete, now valid and clean
                    valid_q[op_way][op_set] <= 1'b1;
                    dirty_q[op_way][op_set] <= 1'b0;
                end
                // Flush clean hits the walker position
                dcache_bus_pkg::FOP_CLEAN: dirty_q[flush_way][flush_set] <= 1'b0;
                default: ;
            endcase
        end
    end

    // Tag and data updates
    always_ff @(posedge CLK) begin
        case (frame_op)
            dcache_bus_pkg::FOP_WRITE:
                data_q[op_way][op_set][lookup_addr.blkoff] <= store_word;
            dcache_bus_pkg::FOP_FILL0:
                data_q[op_way][op_set][0] <= fill_word;
            dcache_bus_pkg::FOP_FILL1: begin
                data_q[op_way][op_set][1] <= fill_word;
                tag_q[op_way][op_set]     <= lookup_addr.tag;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: tests/dcache_tb.sv
`default_nettype none

module dcache_tb;

    localparam int CYCLE_LIMIT = 4000;
    localparam dcache_geom_pkg::word_t NO_HIT_LOAD = 32'hBAD1BAD1;

    logic CLK;
    logic nRST;
    logic halt;
    logic flushed;
    int   mem_wait_cycles;
    dcache_bus_pkg::dp_req_t  dp_req;
    dcache_bus_pkg::dp_rsp_t  dp_rsp;
    dcache_bus_pkg::mem_req_t mem_req;
    dcache_bus_pkg::mem_rsp_t mem_rsp;

    // Datapath view of memory, predicts every load
    dcache_geom_pkg::word_t shadow [1024];

    // Cache contents model for hit, victim and flush order
    logic        m_valid [2][8];
    logic        m_dirty [2][8];
    logic [25:0] m_tag   [2][8];
    logic        m_repl;

    // Memory writes seen on the bus and the ones predicted
    dcache_geom_pkg::word_t wr_addr_q [$];
    dcache_geom_pkg::word_t wr_data_q [$];
    dcache_geom_pkg::word_t exp_addr_q [$];
    dcache_geom_pkg::word_t exp_data_q [$];

    int     errors;
    int     tests_passed;
    int     tests_failed;
    int     xfers;
    int     cycles;
    int     err0;
    integer seed;
    logic   prev_pending;
    dcache_bus_pkg::mem_req_t prev_req;

    dcache_top dut0 (
        .CLK(CLK), .nRST(nRST), .dp_req(dp_req), .dp_rsp(dp_rsp), .halt(halt),
        .flushed(flushed), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    tb_main_memory mem0 (
        .CLK(CLK), .nRST(nRST), .req(mem_req), .rsp(mem_rsp),
        .wait_cycles(mem_wait_cycles)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Run length guard
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the cache stopped responding", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Bus monitor, sampled mid cycle where everything has settled
    always @(negedge CLK) begin
        if (nRST) begin
            assert (!prev_pending || mem_req == prev_req) else begin
                $display("Memory request changed at %0t while wait was high", $time);
                errors++;
            end
            assert (!(mem_req.ren && mem_req.wen)) else begin
                $display("Memory read and write both high at %0t", $time);
                errors++;
            end
            assert (!(flushed && mem_req.wen)) else begin
                $display("Memory write at %0t after flushed went high", $time);
                errors++;
            end
            // Word accepted at the coming edge
            if ((mem_req.ren || mem_req.wen) && !mem_rsp.dwait) begin
                xfers++;
                if (mem_req.wen) begin
                    wr_addr_q.push_back(mem_req.addr);
                    wr_data_q.push_back(mem_req.store);
                end
            end
            prev_pending = (mem_req.ren || mem_req.wen) && mem_rsp.dwait;
            prev_req     = mem_req;
        end
    end

    task automatic check_word(input string name, input dcache_geom_pkg::word_t exp,
                              input dcache_geom_pkg::word_t got);
        assert (got === exp) else begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Both words of a block, in word 0 then word 1 order
    task automatic expect_block_write(input logic [25:0] tag, input logic [2:0] idx);
        dcache_geom_pkg::word_t base;
        base = {tag, idx, 3'b000};
        exp_addr_q.push_back(base);
        exp_data_q.push_back(shadow[base[11:2]]);
        exp_addr_q.push_back(base + 4);
        exp_data_q.push_back(shadow[base[11:2] + 1]);
    endtask

    task automatic check_writes(input int start);
        int n;
        n = wr_addr_q.size() - start;
        assert (n == exp_addr_q.size()) else begin
            $display("Memory saw %0d writes by %0t, %0d were expected", n, $time,
                     exp_addr_q.size());
            errors++;
        end
        for (int i = 0; i < n && i < exp_addr_q.size(); i++) begin
            check_word("mem_req.addr", exp_addr_q[i], wr_addr_q[start + i]);
            check_word("mem_req.store", exp_data_q[i], wr_data_q[start + i]);
        end
    endtask

    // One request held until hit, then dropped
    task automatic access(input logic wr, input dcache_geom_pkg::word_t addr,
                          input dcache_geom_pkg::word_t data, output int cyc);
        logic [2:0]  idx;
        logic [25:0] tag;
        logic        way;
        logic        hit_pred;
        int          wr_start;
        idx      = addr[5:3];
        tag      = addr[31:6];
        hit_pred = 1'b0;
        way      = m_repl;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                hit_pred = 1'b1;
                way      = w[0];
            end
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        // Miss fills the replacement way, dirty victim goes out first
        if (!hit_pred) begin
            if (m_valid[way][idx] && m_dirty[way][idx]) begin
                expect_block_write(m_tag[way][idx], idx);
            end
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
            m_tag[way][idx]   = tag;
            m_repl            = ~m_repl;
        end
        wr_start     = wr_addr_q.size();
        dp_req.ren   = !wr;
        dp_req.wen   = wr;
        dp_req.addr  = dcache_geom_pkg::dcache_addr_t'(addr);
        dp_req.store = data;
        cyc = 0;
        do begin
            @(negedge CLK);
            cyc++;
            if (!dp_rsp.hit) begin
                check_word("dp_rsp.load", NO_HIT_LOAD, dp_rsp.load);
            end
        end while (!dp_rsp.hit);
        assert (hit_pred ? cyc == 1 : cyc > 1) else begin
            $display("Access to %h at %0t took %0d cycles against a predicted %s", addr,
                     $time, cyc, hit_pred ? "hit" : "miss");
            errors++;
        end
        if (wr) begin
            shadow[addr[11:2]] = data;
            m_dirty[way][idx]  = 1'b1;
        end else begin
            check_word("dp_rsp.load", shadow[addr[11:2]], dp_rsp.load);
        end
        @(posedge CLK);
        #2;
        dp_req.ren = 1'b0;
        dp_req.wen = 1'b0;
        check_writes(wr_start);
    endtask

    task automatic read_miss_then_hit(input dcache_geom_pkg::word_t off);
        int cyc;
        int xfers_before;
        access(1'b0, 32'h100 + off, '0, cyc);
        xfers_before = xfers;
        // Other word of the block is already there
        access(1'b0, 32'h104 + off, '0, cyc);
        assert (cyc == 1 && xfers == xfers_before) else begin
            $display("Second read in the block stalled or used memory at %0t", $time);
            errors++;
        end
    endtask

    task automatic write_hit(input dcache_geom_pkg::word_t off);
        int cyc;
        int wr_before;
        dcache_geom_pkg::word_t data;
        access(1'b0, 32'h208 + off, '0, cyc);
        data      = $random(seed);
        wr_before = wr_addr_q.size();
        access(1'b1, 32'h20C + off, data, cyc);
        assert (cyc == 1 && wr_addr_q.size() == wr_before) else begin
            $display("Write hit stalled or wrote to memory at %0t", $time);
            errors++;
        end
        access(1'b0, 32'h20C + off, '0, cyc);
    endtask

    // Three tags in one set, first block dirty when the third arrives
    task automatic dirty_eviction(input dcache_geom_pkg::word_t off);
        int cyc;
        int wr_before;
        access(1'b0, 32'h410 + off, '0, cyc);
        access(1'b1, 32'h414 + off, $random(seed), cyc);
        access(1'b0, 32'h810 + off, '0, cyc);
        wr_before = wr_addr_q.size();
        access(1'b0, 32'hC10 + off, '0, cyc);
        assert (wr_addr_q.size() == wr_before + 2) else begin
            $display("Third block at %0t did not write back the dirty first block", $time);
            errors++;
        end
    endtask

    task automatic random_mix();
        int cyc;
        dcache_geom_pkg::word_t addr;
        dcache_geom_pkg::word_t data;
        for (int i = 0; i < 150; i++) begin
            // 64 words, four tags per set
            addr = ($random(seed) & 32'h3F) << 2;
            data = $random(seed);
            access(data[0], addr, $random(seed), cyc);
        end
    endtask

    task automatic flush_check();
        int wr_start;
        exp_addr_q.delete();
        exp_data_q.delete();
        // Way 0 sets 0 to 7, then way 1
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 8; s++) begin
                if (m_valid[w][s] && m_dirty[w][s]) begin
                    expect_block_write(m_tag[w][s], s[2:0]);
                    m_dirty[w][s] = 1'b0;
                end
            end
        end
        wr_start = wr_addr_q.size();
        halt     = 1'b1;
        while (!flushed) begin
            @(negedge CLK);
        end
        // Quiet bus after flushed is watched by the monitor
        repeat (4) @(negedge CLK);
        check_writes(wr_start);
        for (int i = 0; i < 1024; i++) begin
            check_word($sformatf("mem0.mem[%0d]", i), shadow[i], mem0.mem[i]);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        seed            = 32'he025;
        errors          = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        xfers           = 0;
        cycles          = 0;
        prev_pending    = 1'b0;
        prev_req        = '0;
        nRST            = 1'b0;
        halt            = 1'b0;
        dp_req          = '0;
        mem_wait_cycles = 0;
        m_repl          = 1'b0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 8; s++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = mem0.mem[i];
        end

        err0 = errors;
        read_miss_then_hit(32'h0);
        report_test("read miss then hit", err0);
        err0 = errors;
        write_hit(32'h0);
        report_test("write hit", err0);
        err0 = errors;
        dirty_eviction(32'h0);
        report_test("dirty eviction", err0);

        // Same sequences in fresh sets, slow memory
        mem_wait_cycles = 3;
        err0 = errors;
        read_miss_then_hit(32'h20);
        write_hit(32'h20);
        dirty_eviction(32'h20);
        report_test("wait states", err0);

        mem_wait_cycles = 1;
        err0 = errors;
        random_mix();
        report_test("random mix", err0);
        err0 = errors;
        flush_check();
        report_test("flush", err0);

        $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_main_memory.sv
`default_nettype none

module tb_main_memory (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_bus_pkg::mem_req_t req,
    output dcache_bus_pkg::mem_rsp_t rsp,
    input  int                       wait_cycles
);

    localparam int DEPTH = 1024;

    // Word storage, 4 KB of address space
    dcache_geom_pkg::word_t mem [DEPTH];

    // Wait cycles already spent on the current word
    int         count_q;
    logic       active;
    logic [9:0] widx;

    // Preset from the whole word index through a multiplicative hash
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = (dcache_geom_pkg::word_t'(i + 1) * 32'h9E3779B1) ^
                     (dcache_geom_pkg::word_t'(i) << 22);
        end
    end

    assign active    = req.ren || req.wen;
    assign widx      = req.addr[11:2];
    // Wait stays high until the programmed count has passed
    assign rsp.dwait = active && (count_q < wait_cycles);
    assign rsp.load  = mem[widx];

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count_q <= 0;
        end else if (!active) begin
            count_q <= 0;
        end else if (rsp.dwait) begin
            count_q <= count_q + 1;
        end else begin
            // Word done, next transfer starts counting again
            count_q <= 0;
            if (req.wen) begin
                mem[widx] <= req.store;
            end
        end
    end

endmodule

`default_nettype wire
